// File: logic/icache_if_pkg.sv
// Shared widths and types for the fetch-side icache interface
// Sv39-style split, 40-bit VA with a 28-bit VPN and a 12-bit page offset
// Lines are 16 bytes, so the line tag is vaddr[39:4]
// Page faults are not carried, a TLB exception maps to an access fault

package icache_if_pkg;

    localparam int ADDR_SIZE = 40;  // Virtual address width
    localparam int LINE_BITS = 128; // One cache line
    localparam int WORD_BITS = 32;  // One instruction
    localparam int VPN_BITS  = 28;  // vaddr[39:12]
    localparam int IDX_BITS  = 12;  // vaddr[11:0], page offset used as index
    localparam int BLK_LSB   = 4;   // First tag bit above the line offset

    typedef logic [ADDR_SIZE-1:0] addr_t;
    typedef logic [LINE_BITS-1:0] icache_line_t;
    typedef logic [VPN_BITS-1:0]  icache_vpn_t;
    typedef logic [IDX_BITS-1:0]  icache_idx_t;

    // Fetch to interface, held until a valid response
    typedef struct packed {
        logic  valid;
        addr_t vaddr;
    } fetch_req_t;

    // Interface to fetch
    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] data;               // Zero on a fault
        logic                 instr_access_fault;
    } fetch_resp_t;

    typedef struct packed {
        logic        valid;
        logic        kill;  // Drops the outstanding request
        icache_idx_t idx;
        icache_vpn_t vpn;
    } icache_req_t;

    typedef struct packed {
        logic         valid;
        addr_t        vaddr;      // Address the line was fetched for
        icache_line_t datablock;
    } icache_resp_t;

    typedef enum logic [1:0] {
        ResetState,
        NoReq,
        ReqValid,
        Replay
    } icache_state_t;

endpackage

// File: logic/icache_retry_timer.sv
// Wait counter for an outstanding icache request
// Saturates at RETRY_LIMIT and holds there until cleared
// RETRY_LIMIT must be at least 1
`timescale 1ns/1ps

module icache_retry_timer #(
    parameter int unsigned RETRY_LIMIT = 16
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic wait_en_i,      // Request still waiting
    input  logic wait_clr_i,     // Issue, response or kill
    output logic wait_expired_o
);

    localparam int CNT_W = $clog2(RETRY_LIMIT + 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (wait_clr_i) begin
            cnt_q <= '0;                 // Clear wins over counting
        end else if (wait_en_i && !wait_expired_o) begin
            cnt_q <= cnt_q + 1'b1;       // Stop at the limit
        end
    end

    // High for as long as the limit is reached
    assign wait_expired_o = (cnt_q == CNT_W'(RETRY_LIMIT));

endmodule

// File: logic/icache_line_buffer.sv
// Single-line buffer in front of the instruction cache
// Fills on any valid response whose line matches the current fetch PC
// An invalidate in the same cycle as a fill leaves the buffer empty
// Data returned during a fill comes straight from the response bus
`timescale 1ns/1ps

module icache_line_buffer
    import icache_if_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  addr_t                fetch_vaddr_i,
    input  icache_resp_t         icache_resp_i,
    input  logic                 invalidate_i,  // PTW invalidation pulse
    output logic                 buf_hit_o,
    output logic                 resp_match_o,
    output logic [WORD_BITS-1:0] word_o
);

    localparam int TAG_W = ADDR_SIZE - BLK_LSB;

    icache_line_t       line_q;      // Buffered line
    icache_line_t       line_sel;
    logic [TAG_W-1:0]   tag_q;       // Line address of line_q
    logic [TAG_W-1:0]   fetch_tag;
    logic [TAG_W-1:0]   resp_tag;
    logic               valid_q;
    logic               fill;
    logic [BLK_LSB-3:0] word_idx;    // Word within the line

    assign fetch_tag = fetch_vaddr_i[ADDR_SIZE-1:BLK_LSB];
    assign resp_tag  = icache_resp_i.vaddr[ADDR_SIZE-1:BLK_LSB];
    assign word_idx  = fetch_vaddr_i[BLK_LSB-1:2];

    // Late responses for an older line do not match and are ignored
    assign resp_match_o = (resp_tag == fetch_tag);
    assign fill         = icache_resp_i.valid & resp_match_o;

    // Valid bit
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (invalidate_i) begin
            valid_q <= 1'b0;           // Invalidate beats a fill
        end else if (fill) begin
            valid_q <= 1'b1;
        end
    end

    // Line and tag, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (fill) begin
            line_q <= icache_resp_i.datablock;
            tag_q  <= fetch_tag;
        end
    end

    assign buf_hit_o = valid_q & (tag_q == fetch_tag);

    // Bypass the arriving line so a fill answers in its own cycle
    assign line_sel = fill ? icache_resp_i.datablock : line_q;

    always_comb begin
        word_o = line_sel[word_idx*WORD_BITS +: WORD_BITS]; // vaddr[3:2] picks the word
    end

endmodule

// File: logic/icache_ctrl_fsm.sv
// Request sequencer for the fetch-side icache interface
// A request counts as accepted only in a cycle with valid, ready and no TLB miss
// Ready low or a TLB miss while waiting forces a replay of the same line
// A line change while a request is outstanding kills it and may issue anew
// resp_ready is held high, responses are never back-pressured
`timescale 1ns/1ps

module icache_ctrl_fsm
    import icache_if_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  fetch_req_t fetch_req_i,
    input  logic       buf_hit_i,      // Fetch line already buffered
    input  logic       resp_valid_i,
    input  logic       resp_match_i,   // Response tag equals fetch tag
    input  logic       req_ready_i,
    input  logic       tlb_miss_i,
    input  logic       tlb_xcpt_i,
    input  logic       wait_expired_i,
    output logic       req_valid_o,
    output logic       req_kill_o,
    output logic       resp_ready_o,
    output logic       wait_en_o,
    output logic       wait_clr_o,
    output logic       fetch_valid_o,
    output logic       fetch_fault_o
);

    icache_state_t                state_q, state_d;
    logic [ADDR_SIZE-BLK_LSB-1:0] req_tag_q, req_tag_d; // Line of the last issued request
    logic [ADDR_SIZE-BLK_LSB-1:0] fetch_tag;
    logic                         fill_hit;
    logic                         access_needed;
    logic                         line_change;
    logic                         issue_ok;
    logic                         resp_ok;

    assign fetch_tag   = fetch_req_i.vaddr[ADDR_SIZE-1:BLK_LSB];
    assign fill_hit    = resp_valid_i & resp_match_i;    // Line for this PC arrives now
    assign line_change = (req_tag_q != fetch_tag);
    assign issue_ok    = req_ready_i & ~tlb_miss_i;      // Request would be taken this cycle

    // Go to the cache only when nothing local can answer
    assign access_needed = fetch_req_i.valid & ~buf_hit_i & ~fill_hit & ~tlb_xcpt_i;

    // Hit, fill or fault all answer fetch in the same cycle
    assign resp_ok = fetch_req_i.valid & (buf_hit_i | fill_hit | tlb_xcpt_i);

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= ResetState;
            req_tag_q <= '0;
        end else begin
            state_q   <= state_d;
            req_tag_q <= req_tag_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        req_tag_d     = req_tag_q;
        req_valid_o   = 1'b0;
        req_kill_o    = 1'b0;
        fetch_valid_o = 1'b0;
        fetch_fault_o = 1'b0;
        case (state_q)
            ResetState: begin
                state_d = NoReq; // Outputs stay low for this cycle
            end
            NoReq: begin
                fetch_valid_o = resp_ok;
                fetch_fault_o = fetch_req_i.valid & tlb_xcpt_i;
                if (access_needed) begin
                    req_valid_o = 1'b1;
                    req_tag_d   = fetch_tag;
                    state_d     = issue_ok ? ReqValid : Replay;
                end
            end
            ReqValid, Replay: begin
                fetch_valid_o = resp_ok;
                fetch_fault_o = fetch_req_i.valid & tlb_xcpt_i;
                if (line_change) begin
                    // PC moved away, drop the old request
                    req_kill_o = 1'b1;
                    if (access_needed) begin
                        req_valid_o = 1'b1;  // New line goes out with the kill
                        req_tag_d   = fetch_tag;
                        state_d     = issue_ok ? ReqValid : Replay;
                    end else begin
                        state_d = NoReq;
                    end
                end else if (fill_hit) begin
                    state_d = NoReq;         // Answered, line now buffered
                end else if (state_q == ReqValid) begin
                    if (!req_ready_i || tlb_miss_i || wait_expired_i) begin
                        state_d = Replay;
                    end
                end else if (!access_needed) begin
                    state_d = NoReq;         // Fetch dropped or faulted
                end else if (issue_ok) begin
                    req_valid_o = 1'b1;      // Re-issue the same line
                    state_d     = ReqValid;
                end
            end
            default: begin
                state_d = ResetState;
            end
        endcase
    end

    assign resp_ready_o = 1'b1; // Responses are always taken

    // Retry timer runs only while waiting on an accepted request
    assign wait_en_o  = (state_q == ReqValid);
    assign wait_clr_o = req_valid_o | req_kill_o | fill_hit;

endmodule

// File: logic/icache_fetch_if.sv
// Fetch-side icache interface top
// Fetch must hold its request stable until it sees a valid response
// TLB request mirrors the cache request and carries the same VPN
// A TLB exception answers fetch at once with a zero word and the fault bit
`timescale 1ns/1ps

module icache_fetch_if
    import icache_if_pkg::*;
#(
    parameter int unsigned RETRY_LIMIT = 16
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  fetch_req_t   fetch_req_i,
    output fetch_resp_t  fetch_resp_o,
    output icache_req_t  icache_req_o,
    input  logic         icache_req_ready_i,
    input  icache_resp_t icache_resp_i,
    output logic         icache_resp_ready_o,
    output logic         icache_invalidate_o,
    output logic         tlb_req_valid_o,
    output icache_vpn_t  tlb_req_vpn_o,
    input  logic         tlb_resp_miss_i,
    input  logic         tlb_resp_xcpt_i,
    input  logic         ptw_invalidate_i
);

    logic                 buf_hit;
    logic                 resp_match;
    logic                 wait_en;
    logic                 wait_clr;
    logic                 wait_expired;
    logic                 req_valid;
    logic                 req_kill;
    logic                 fetch_valid;
    logic                 fetch_fault;
    logic [WORD_BITS-1:0] buf_word;
    icache_vpn_t          fetch_vpn;
    icache_idx_t          fetch_idx;

    // Split the PC for the cache and TLB ports
    assign fetch_vpn = fetch_req_i.vaddr[ADDR_SIZE-1:IDX_BITS];
    assign fetch_idx = fetch_req_i.vaddr[IDX_BITS-1:0];

    icache_ctrl_fsm u_ctrl (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .fetch_req_i    (fetch_req_i),
        .buf_hit_i      (buf_hit),
        .resp_valid_i   (icache_resp_i.valid),
        .resp_match_i   (resp_match),
        .req_ready_i    (icache_req_ready_i),
        .tlb_miss_i     (tlb_resp_miss_i),
        .tlb_xcpt_i     (tlb_resp_xcpt_i),
        .wait_expired_i (wait_expired),
        .req_valid_o    (req_valid),
        .req_kill_o     (req_kill),
        .resp_ready_o   (icache_resp_ready_o),
        .wait_en_o      (wait_en),
        .wait_clr_o     (wait_clr),
        .fetch_valid_o  (fetch_valid),
        .fetch_fault_o  (fetch_fault)
    );

    icache_retry_timer #(
        .RETRY_LIMIT (RETRY_LIMIT)
    ) u_timer (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .wait_en_i      (wait_en),
        .wait_clr_i     (wait_clr),
        .wait_expired_o (wait_expired)
    );

    icache_line_buffer u_buf (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .fetch_vaddr_i (fetch_req_i.vaddr),
        .icache_resp_i (icache_resp_i),
        .invalidate_i  (ptw_invalidate_i),
        .buf_hit_o     (buf_hit),
        .resp_match_o  (resp_match),
        .word_o        (buf_word)
    );

    // Cache request
    assign icache_req_o.valid = req_valid;
    assign icache_req_o.kill  = req_kill;
    assign icache_req_o.idx   = fetch_idx;
    assign icache_req_o.vpn   = fetch_vpn;

    assign icache_invalidate_o = ptw_invalidate_i; // Cache drops its lines too
    assign tlb_req_valid_o     = req_valid;
    assign tlb_req_vpn_o       = fetch_vpn;

    // Fetch response, word forced to zero on a fault
    assign fetch_resp_o.valid              = fetch_valid;
    assign fetch_resp_o.data               = fetch_fault ? '0 : buf_word;
    assign fetch_resp_o.instr_access_fault = fetch_fault;

endmodule

// File: dv/icache_mem_model.sv
// Behavioral instruction cache for the fetch interface testbench
// One request in flight, ready stays low while busy
// Word k of a line is line_addr[31:0] ^ k*0x11111111
// Kill is ignored, a killed line still answers late
`timescale 1ns/1ps

module icache_mem_model
    import icache_if_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  icache_req_t  req_i,
    input  logic         accept_en_i,  // Low while the TLB misses
    input  logic         silent_i,     // Accept but never answer
    input  logic         drop_en_i,    // Random ready drops
    input  logic         ready_off_i,  // Hold ready low
    output logic         ready_o,
    output icache_resp_t resp_o
);

    logic [15:0]  lfsr_q;
    logic         busy_q;
    logic [2:0]   cnt_q;
    addr_t        pend_q;
    logic         ready_q;
    icache_resp_t resp_q;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000); // Galois taps 16,14,13,11
    endfunction

    function automatic icache_line_t make_line(addr_t a);
        icache_line_t l;
        logic [31:0]  base;
        base = {a[31:4], 4'b0000};
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = base ^ (32'(k) * 32'h11111111);
        end
        return l;
    endfunction

    always @(posedge clk_i or negedge rstn_i) begin : seq
        logic [15:0] s;
        logic [1:0]  lat;
        logic [1:0]  drop;
        logic        busy_n;
        if (!rstn_i) begin
            lfsr_q  <= 16'd29014;
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            pend_q  <= '0;
            ready_q <= 1'b0;
            resp_q  <= '0;
        end else begin
            s       = lfsr_q;
            lat[0]  = s[0];
            s       = lfsr_next(s);
            lat[1]  = s[0];
            s       = lfsr_next(s);
            drop[0] = s[0];
            s       = lfsr_next(s);
            drop[1] = s[0];
            s       = lfsr_next(s);
            lfsr_q  <= s;
            busy_n  = busy_q;
            resp_q.valid <= 1'b0;
            if (busy_q) begin
                if (cnt_q == 0) begin
                    resp_q.valid     <= 1'b1;          // Answer the pending line
                    resp_q.vaddr     <= pend_q;
                    resp_q.datablock <= make_line(pend_q);
                    busy_n           = 1'b0;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end else if (req_i.valid && ready_o && accept_en_i && !silent_i) begin
                busy_n = 1'b1;
                pend_q <= {req_i.vpn, req_i.idx};
                cnt_q  <= {1'b0, lat};                 // 1 to 4 cycles to answer
            end
            busy_q  <= busy_n;
            ready_q <= !busy_n && !ready_off_i && !(drop_en_i && (drop == 2'b11));
        end
    end

    // Outputs move on the falling edge like all other stimulus
    always @(negedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ready_o <= 1'b0;
            resp_o  <= '0;
        end else begin
            ready_o <= ready_q;
            resp_o  <= resp_q;
        end
    end

endmodule

// File: dv/tb_icache_fetch_if.sv
// Testbench for the fetch-side icache interface
// Inputs change on the falling edge, checks sample on the rising edge
// The run stops at a cycle limit derived from test count and retry limit
`timescale 1ns/1ps

module tb_icache_fetch_if;
    import icache_if_pkg::*;

    localparam int unsigned RETRY_LIMIT = 8;
    localparam int          MAX_CYCLES  = 6 * 40 * (RETRY_LIMIT + 8);

    logic clk_i = 1'b0;
    logic rstn_i;
    fetch_req_t   fetch_req;
    fetch_resp_t  fetch_resp;
    icache_req_t  icache_req;
    icache_resp_t icache_resp;
    icache_vpn_t  tlb_vpn;
    logic req_ready, resp_ready, inval_out, tlb_valid;
    logic tlb_miss, tlb_xcpt, ptw_inv;
    logic silent, drop_en, ready_off;
    int   errors = 0;
    int   cycles = 0;
    logic [15:0] lfsr = 16'd29014;
    // Reference state kept from the interface rules
    logic        rst_seen_q, got_q, kill_q, inv_q, buf_ok_q;
    logic [35:0] buf_line_q, last_req_line_q;
    int          since_q;

    always #10 clk_i = ~clk_i;  // 20 ns period

    icache_fetch_if #(.RETRY_LIMIT(RETRY_LIMIT)) DUT (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .fetch_req_i (fetch_req), .fetch_resp_o (fetch_resp),
        .icache_req_o (icache_req), .icache_req_ready_i (req_ready),
        .icache_resp_i (icache_resp), .icache_resp_ready_o (resp_ready),
        .icache_invalidate_o (inval_out),
        .tlb_req_valid_o (tlb_valid), .tlb_req_vpn_o (tlb_vpn),
        .tlb_resp_miss_i (tlb_miss), .tlb_resp_xcpt_i (tlb_xcpt),
        .ptw_invalidate_i (ptw_inv)
    );

    icache_mem_model u_mem (
        .clk_i (clk_i), .rstn_i (rstn_i), .req_i (icache_req),
        .accept_en_i (!tlb_miss), .silent_i (silent), .drop_en_i (drop_en),
        .ready_off_i (ready_off), .ready_o (req_ready), .resp_o (icache_resp)
    );

    function automatic logic [31:0] expected_word(addr_t pc);
        logic [31:0] base;
        base = {pc[31:4], 4'b0000};
        return base ^ (32'(pc[3:2]) * 32'h11111111);
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic addr_t random_pc();
        addr_t r;
        r = '0;
        for (int i = 0; i < 38; i++) begin
            r    = {r[38:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return {r[37:0], 2'b00};
    endfunction

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rst_seen_q <= 1'b0;
            got_q      <= 1'b0;
            kill_q     <= 1'b0;
            inv_q      <= 1'b0;
            buf_ok_q   <= 1'b0;
            since_q    <= 0;
        end else begin
            rst_seen_q <= 1'b1;
            got_q      <= fetch_resp.valid;
            kill_q     <= icache_req.kill;
            inv_q      <= ptw_inv;
            if (icache_req.valid) last_req_line_q <= fetch_req.vaddr[39:4];
            if (ptw_inv) begin
                buf_ok_q <= 1'b0;                      // Invalidate beats a fill
            end else if (icache_resp.valid && icache_resp.vaddr[39:4] == fetch_req.vaddr[39:4]) begin
                buf_ok_q   <= 1'b1;
                buf_line_q <= fetch_req.vaddr[39:4];
            end
            if (icache_req.valid || !fetch_req.valid || fetch_resp.valid) since_q <= 0;
            else since_q <= since_q + 1;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a fetch was never answered", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Wrong value seen by an assertion
    task automatic count_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        errors++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    endtask

    task automatic log_failure(string msg);
        errors++;
        $display("%s", msg);
    endtask

    a_reset: assert property (@(posedge clk_i) !rst_seen_q |->
            !icache_req.valid && !icache_req.kill && !tlb_valid && !fetch_resp.valid)
        else count_mismatch("icache_req.valid/kill, tlb_req_valid_o, fetch_resp.valid",
            $sampled({icache_req.valid, icache_req.kill, tlb_valid, fetch_resp.valid}), 64'h0);
    a_resp_ready: assert property (@(posedge clk_i) rst_seen_q |-> resp_ready)
        else count_mismatch("icache_resp_ready_o", $sampled(resp_ready), 64'h1);
    a_data: assert property (@(posedge clk_i) fetch_resp.valid && !tlb_xcpt |->
            !fetch_resp.instr_access_fault && fetch_resp.data == expected_word(fetch_req.vaddr))
        else count_mismatch("fetch_resp.instr_access_fault/data",
            $sampled({fetch_resp.instr_access_fault, fetch_resp.data}),
            {1'b0, expected_word($sampled(fetch_req.vaddr))});
    a_req_addr: assert property (@(posedge clk_i) icache_req.valid |->
            {icache_req.vpn, icache_req.idx} == fetch_req.vaddr)
        else count_mismatch("icache_req.vpn/idx", $sampled({icache_req.vpn, icache_req.idx}),
            $sampled(fetch_req.vaddr));
    a_tlb_vpn: assert property (@(posedge clk_i) tlb_valid |->
            tlb_vpn == fetch_req.vaddr[39:12])
        else count_mismatch("tlb_req_vpn_o", $sampled(tlb_vpn),
            $sampled(fetch_req.vaddr[39:12]));
    a_tlb_mirror: assert property (@(posedge clk_i) tlb_valid == icache_req.valid)
        else count_mismatch("tlb_req_valid_o", $sampled(tlb_valid), $sampled(icache_req.valid));
    a_hit: assert property (@(posedge clk_i) fetch_req.valid && buf_ok_q &&
            buf_line_q == fetch_req.vaddr[39:4] |-> fetch_resp.valid && !icache_req.valid)
        else count_mismatch("fetch_resp.valid/icache_req.valid on hit",
            $sampled({fetch_resp.valid, icache_req.valid}), 64'h2);
    a_retry: assert property (@(posedge clk_i) silent |-> since_q <= RETRY_LIMIT + 1)
        else log_failure($sformatf("Request not re-issued within %0d cycles", RETRY_LIMIT + 2));
    a_kill_once: assert property (@(posedge clk_i) !(icache_req.kill && kill_q))
        else log_failure("Kill stayed high for more than one cycle");
    a_kill_line: assert property (@(posedge clk_i) icache_req.kill |->
            last_req_line_q != fetch_req.vaddr[39:4])
        else log_failure("Kill raised without a line change");
    a_kill_new: assert property (@(posedge clk_i) icache_req.kill && fetch_req.valid &&
            !tlb_xcpt && !icache_resp.valid && !(buf_ok_q && buf_line_q == fetch_req.vaddr[39:4])
            |-> icache_req.valid)
        else count_mismatch("icache_req.valid with kill", $sampled(icache_req.valid), 64'h1);
    a_late: assert property (@(posedge clk_i) icache_resp.valid &&
            icache_resp.vaddr[39:4] != fetch_req.vaddr[39:4] && !tlb_xcpt &&
            !(buf_ok_q && buf_line_q == fetch_req.vaddr[39:4]) |-> !fetch_resp.valid)
        else count_mismatch("fetch_resp.valid on stale line", $sampled(fetch_resp.valid), 64'h0);
    a_inv_pass: assert property (@(posedge clk_i) inval_out == ptw_inv)
        else count_mismatch("icache_invalidate_o", $sampled(inval_out), $sampled(ptw_inv));
    a_inv_miss: assert property (@(posedge clk_i) inv_q && fetch_req.valid && !tlb_xcpt &&
            !icache_resp.valid |-> icache_req.valid)
        else count_mismatch("icache_req.valid after invalidate", $sampled(icache_req.valid),
            64'h1);
    a_fault: assert property (@(posedge clk_i) rst_seen_q && fetch_req.valid && tlb_xcpt |->
            fetch_resp.valid && fetch_resp.instr_access_fault && fetch_resp.data == '0)
        else count_mismatch("fetch_resp.valid/instr_access_fault/data on fault",
            $sampled({fetch_resp.valid, fetch_resp.instr_access_fault, fetch_resp.data}),
            {2'b11, 32'h0});

    task automatic drive_fetch(addr_t pc);
        fetch_req.valid = 1'b1;
        fetch_req.vaddr = pc;
    endtask

    // Present a PC and hold it until the DUT answers
    task automatic fetch_and_wait(addr_t pc);
        drive_fetch(pc);
        do @(negedge clk_i); while (!got_q);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic report(int num, string name, int err_before);
        $display("test %0d %s finished, %0d errors", num, name, errors - err_before);
    endtask

    initial begin
        int    e;
        addr_t pc;
        rstn_i = 1'b0;
        drive_fetch(random_pc());                 // Valid PC held through reset
        {tlb_miss, tlb_xcpt, ptw_inv} = 3'b000;
        {silent, drop_en, ready_off}  = 3'b000;
        e = errors;
        repeat (8) @(negedge clk_i);
        rstn_i = 1'b1;
        fetch_and_wait(fetch_req.vaddr);          // First fetch after reset
        report(1, "reset", e);

        e = errors;
        drop_en = 1'b1;
        for (int i = 0; i < 40; i++) fetch_and_wait(random_pc());
        report(2, "miss and fill", e);

        e = errors;
        for (int i = 0; i < 10; i++) begin
            pc = random_pc();
            fetch_and_wait(pc);                   // Fills the line
            for (int w = 0; w < 4; w++) fetch_and_wait({pc[39:4], 2'(w), 2'b00});
        end
        report(3, "buffer hit", e);

        e = errors;
        drop_en = 1'b0;
        ready_off = 1'b1;
        idle_cycles(1);                           // Ready is low before the PC arrives
        drive_fetch(random_pc());
        idle_cycles(5);
        ready_off = 1'b0;
        fetch_and_wait(fetch_req.vaddr);
        tlb_miss = 1'b1;
        drive_fetch(random_pc());
        idle_cycles(5);
        tlb_miss = 1'b0;
        fetch_and_wait(fetch_req.vaddr);
        silent = 1'b1;
        drive_fetch(random_pc());
        idle_cycles(3 * (RETRY_LIMIT + 2));
        silent = 1'b0;
        fetch_and_wait(fetch_req.vaddr);
        report(4, "replay and retry", e);

        e = errors;
        drop_en = 1'b1;
        for (int i = 0; i < 10; i++) begin
            drive_fetch(random_pc());
            @(negedge clk_i);
            fetch_and_wait(random_pc());          // Moves the line while outstanding
            idle_cycles(5);                       // Lets the old line answer late
        end
        report(5, "line change and kill", e);

        e = errors;
        for (int i = 0; i < 5; i++) begin
            pc = random_pc();
            fetch_and_wait(pc);
            ptw_inv = 1'b1;
            fetch_and_wait(pc);                   // Hit in the invalidate cycle
            ptw_inv = 1'b0;
            fetch_and_wait(pc);                   // Misses again
            tlb_xcpt = 1'b1;
            fetch_and_wait(random_pc());
            tlb_xcpt = 1'b0;
        end
        fetch_req.valid = 1'b0;
        idle_cycles(4);
        report(6, "invalidate and fault", e);

        $display("6 tests run, %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: fetch_icache.f
logic/icache_if_pkg.sv
logic/icache_retry_timer.sv
logic/icache_line_buffer.sv
logic/icache_ctrl_fsm.sv
logic/icache_fetch_if.sv
dv/icache_mem_model.sv
dv/tb_icache_fetch_if.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch-side icache interface regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_icache.f \
    --top-module tb_icache_fetch_if \
    -o sim_icache

./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

echo "Simulation finished without errors"
exit 0
